//--- run.sh
#!/usr/bin/env bash
# Build the lane testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
       --top-module tb_lane -f tb.f -o tb_lane_sim \
  && ./obj_dir/tb_lane_sim | tee /dev/stderr | grep -xF "PASS: all tests" > /dev/null \
  || { echo "Lane simulation did not pass" >&2; exit 1; }

//--- tb.f
verilog/lane_pkg.sv
verilog/spill_register.sv
verilog/lane_sequencer.sv
verilog/elem_counter.sv
verilog/vector_regfile.sv
verilog/operand_queue.sv
verilog/vector_alu.sv
verilog/lane.sv
tests/tb_clock.sv
tests/tb_lane.sv

//--- tests/tb_clock.sv
// Clock and reset source for the lane testbench, 10 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Released on the edge after the last reset cycle
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/tb_lane.sv
// Testbench for the vector lane with a register model and assertion checks on readback
`timescale 1ns/1ps
`default_nettype none

module tb_lane;

  import lane_pkg::*;

  localparam int NrFills   = NrVRegs;
  localparam int NrMviRuns = 4;
  localparam int NrArith   = 7;
  localparam int NrInstr   = NrFills + 2 * NrMviRuns + 2 * NrArith;
  localparam int MaxCycles = 200 * NrInstr;

  logic      clk_i;
  logic      rst_ni;
  logic      req_valid_i;
  logic      req_ready_o;
  lane_req_t req_i;
  logic      rd_valid_o;
  elem_t     rd_data_o;
  logic      rd_ready_i;
  logic      done_o;

  // Reference state
  elem_t       vrf_model [NrVRegs][VLenElems];
  elem_t       exp_q [$];
  elem_t       exp_head    = '0;
  int          exp_pending = 0;
  int          errors      = 0;
  int          accept_cnt  = 0;
  int          done_cnt    = 0;
  int          cycle_cnt   = 0;
  logic        seen_req    = 1'b0;
  logic [31:0] stim_rng;

  tb_clock #(
    .ResetCycles(16)
  ) i_clock (
    .clk_o (clk_i),
    .rst_no(rst_ni)
  );

  lane lane_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .req_i      (req_i),
    .rd_valid_o (rd_valid_o),
    .rd_data_o  (rd_data_o),
    .rd_ready_i (rd_ready_i),
    .done_o     (done_o)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw(output logic [31:0] value);
    stim_rng = xorshift32(stim_rng);
    value    = stim_rng;
  endtask

  function automatic elem_t expected_result(input lane_op_e op, input elem_t a, input elem_t b);
    case (op)
      VADD:    return a + b;
      VSUB:    return a - b;
      VAND:    return a & b;
      VOR:     return a | b;
      VXOR:    return a ^ b;
      default: return '0;
    endcase
  endfunction

  // Hand one request to the lane and wait for its completion pulse
  task automatic issue_req(input lane_op_e op, input vreg_t vd, input vreg_t vs1,
                           input vreg_t vs2, input elem_t scalar, input vl_t vl);
    lane_req_t req;
    req = '{op: op, vd: vd, vs1: vs1, vs2: vs2, scalar: scalar, vl: vl};
    req_valid_i <= 1'b1;
    req_i       <= req;
    @(posedge clk_i);
    while (!req_ready_o) @(posedge clk_i);
    req_valid_i <= 1'b0;
    do @(posedge clk_i); while (!done_o);
  endtask

  task automatic fill_index(input vreg_t vd, input elem_t scalar, input vl_t vl);
    for (int i = 0; i < int'(vl); i++) begin
      vrf_model[vd][eidx_t'(i)] = scalar + elem_t'(i);
    end
    issue_req(VMVI, vd, '0, '0, scalar, vl);
  endtask

  task automatic read_back(input vreg_t vs, input vl_t vl);
    for (int i = 0; i < int'(vl); i++) begin
      exp_q.push_back(vrf_model[vs][eidx_t'(i)]);
    end
    issue_req(VREAD, '0, vs, '0, '0, vl);
  endtask

  task automatic apply_op(input lane_op_e op, input vreg_t vd, input vreg_t vs1,
                          input vreg_t vs2, input vl_t vl);
    elem_t a;
    elem_t b;
    for (int i = 0; i < int'(vl); i++) begin
      a = vrf_model[vs1][eidx_t'(i)];
      b = vrf_model[vs2][eidx_t'(i)];
      vrf_model[vd][eidx_t'(i)] = expected_result(op, a, b);
    end
    issue_req(op, vd, vs1, vs2, '0, vl);
  endtask

  //////////////////////////////
  // Monitor and watchdog
  //////////////////////////////

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (rst_ni) begin
      if (req_valid_i) begin
        seen_req <= 1'b1;
      end
      if (req_valid_i && req_ready_o) begin
        accept_cnt <= accept_cnt + 1;
      end
      if (done_o) begin
        done_cnt <= done_cnt + 1;
      end
      if (rd_valid_o && rd_ready_i && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      exp_head    <= (exp_q.size() != 0) ? exp_q[0] : '0;
      exp_pending <= exp_q.size();
    end
  end

  always @(posedge clk_i) begin
    if (cycle_cnt >= MaxCycles) begin
      $display("Timeout: run stopped after %0d cycles with %0d of %0d instructions done",
               cycle_cnt, done_cnt, NrInstr);
      $display("Errors: %0d before the timeout", errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_idle_after_reset: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !seen_req |-> req_ready_o && !rd_valid_o && !done_o
  ) else begin
    errors = errors + 1;
    $display("Error at %0t: lane left its idle state before the first request", $time);
  end

  a_readback_value: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rd_valid_o && rd_ready_i |-> rd_data_o == exp_head
  ) else begin
    errors = errors + 1;
    $display("[FAIL] %0t rd_data_o: got %h, expected %h",
             $time, $sampled(rd_data_o), $sampled(exp_head));
  end

  a_readback_expected: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rd_valid_o && rd_ready_i |-> exp_pending != 0
  ) else begin
    errors = errors + 1;
    $display("Error at %0t: readback transfer when no element was expected", $time);
  end

  a_readback_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rd_valid_o && !rd_ready_i |=> rd_valid_o && $stable(rd_data_o)
  ) else begin
    errors = errors + 1;
    $display("Error at %0t: readback element dropped or changed while stalled", $time);
  end

  // Done only after every readback element has left the lane
  a_done_complete: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    done_o |-> exp_pending == 0
  ) else begin
    errors = errors + 1;
    $display("Error at %0t: done_o with %0d readback elements missing",
             $time, $sampled(exp_pending));
  end

  a_done_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o
  ) else begin
    errors = errors + 1;
    $display("Error at %0t: done_o held high for more than one cycle", $time);
  end

  a_done_per_request: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    done_o |-> done_cnt < accept_cnt
  ) else begin
    errors = errors + 1;
    $display("Error at %0t: done_o without an outstanding request", $time);
  end

  // rd_ready_i from its own random stream, high about three cycles in four
  initial begin : ready_driver
    logic [31:0] ready_rng;
    ready_rng  = ~32'hb20b;
    rd_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      ready_rng = xorshift32(ready_rng);
      rd_ready_i <= (ready_rng[1:0] != 2'b00);
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin : stimulus
    logic [31:0] r;
    vreg_t       vd;
    vreg_t       vs1;
    vreg_t       vs2;
    vl_t         vl;
    lane_op_e    op;
    req_valid_i = 1'b0;
    req_i       = '0;
    stim_rng    = 32'hb20b;
    for (int v = 0; v < NrVRegs; v++) begin
      for (int e = 0; e < VLenElems; e++) begin
        vrf_model[v][e] = '0;
      end
    end
    wait (rst_ni == 1'b1);
    repeat (4) @(posedge clk_i);

    // Fill every register over its full length
    for (int v = 0; v < NrFills; v++) begin
      draw(r);
      fill_index(vreg_t'(v), r, vl_t'(VLenElems));
    end

    // Index fill then readback with the shortest and longest lengths first
    for (int k = 0; k < NrMviRuns; k++) begin
      draw(r);
      vd = vreg_t'(r[2:0]);
      if (k == 0) begin
        vl = vl_t'(1);
      end else if (k == 1) begin
        vl = vl_t'(VLenElems);
      end else begin
        vl = vl_t'(r[11:9]) + vl_t'(1);
      end
      draw(r);
      fill_index(vd, r, vl);
      read_back(vd, vl);
    end

    // Each ALU op once and then random ops at the length limits
    for (int k = 0; k < NrArith; k++) begin
      draw(r);
      vd  = vreg_t'(r[2:0]);
      vs1 = vreg_t'(r[5:3]);
      vs2 = vreg_t'(r[8:6]);
      vl  = vl_t'(r[11:9]) + vl_t'(1);
      if (k < 5) begin
        op = lane_op_e'(3'(k));
      end else begin
        op = lane_op_e'(3'(r[31:16] % 16'd5));
        vl = (k == 5) ? vl_t'(1) : vl_t'(VLenElems);
      end
      apply_op(op, vd, vs1, vs2, vl);
      read_back(vd, vl_t'(VLenElems));
    end

    repeat (4) @(posedge clk_i);
    check_done_count: assert (done_cnt == accept_cnt && accept_cnt == NrInstr) else begin
      errors = errors + 1;
      $display("Error: %0d requests accepted and %0d done pulses for %0d instructions",
               accept_cnt, done_cnt, NrInstr);
    end
    $display("Errors: %0d over %0d instructions in %0d cycles", errors, NrInstr, cycle_cnt);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/elem_counter.sv
// Element counter tracking issued and retired elements against the vector length
`timescale 1ns/1ps
`default_nettype none

module elem_counter (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            start_i,
  input  lane_pkg::vl_t   vl_i,
  input  logic            issue_i,
  input  logic            retire_i,
  output lane_pkg::eidx_t issue_idx_o,
  output logic            issue_last_o,
  output logic            all_retired_o
);

  import lane_pkg::*;

  vl_t vl_q;
  vl_t issue_cnt_q;
  vl_t retire_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vl_q         <= '0;
      issue_cnt_q  <= '0;
      retire_cnt_q <= '0;
    end else if (start_i) begin
      vl_q         <= vl_i;
      issue_cnt_q  <= '0;
      retire_cnt_q <= '0;
    end else begin
      if (issue_i) begin
        issue_cnt_q <= issue_cnt_q + vl_t'(1);
      end
      if (retire_i) begin
        retire_cnt_q <= retire_cnt_q + vl_t'(1);
      end
    end
  end

  assign issue_idx_o   = eidx_t'(issue_cnt_q);
  assign issue_last_o  = (issue_cnt_q == vl_q - vl_t'(1));
  assign all_retired_o = (retire_cnt_q == vl_q);

  // A retire always belongs to an element issued earlier
  a_retire_after_issue: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    retire_i |-> retire_cnt_q < issue_cnt_q
  );

endmodule

`default_nettype wire

//--- verilog/lane.sv
// Vector lane top level connecting intake, sequencer, register file, operand queue and ALU
`timescale 1ns/1ps
`default_nettype none

module lane (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  lane_pkg::lane_req_t req_i,
  output logic                rd_valid_o,
  output lane_pkg::elem_t     rd_data_o,
  input  logic                rd_ready_i,
  output logic                done_o
);

  import lane_pkg::*;

  lane_req_t  req, cur_req;
  logic       req_valid, req_ready;
  logic       cnt_start, issue_last, all_retired, lane_idle;
  logic       opq_credit, rd_issue, retire;
  vaddr_t     rd_addr_a, rd_addr_b, wr_addr;
  eidx_t      issue_idx;
  elem_t      rd_data_a, rd_data_b, wr_data, alu_rd_data;
  logic       wr_en, alu_rd_valid, alu_rd_ready;
  opq_entry_t opq_head;
  logic       opq_head_valid, opq_head_ready;

  //////////////////////////////
  // Intake
  //////////////////////////////

  spill_register #(
    .T(lane_req_t)
  ) i_req_spill (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(req_valid_i),
    .ready_o(req_ready_o),
    .data_i (req_i),
    .valid_o(req_valid),
    .ready_i(req_ready),
    .data_o (req)
  );

  // Readback finishes only once its last element has left the lane
  assign lane_idle = all_retired && !rd_valid_o;

  lane_sequencer i_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .req_i        (req),
    .cur_req_o    (cur_req),
    .cnt_start_o  (cnt_start),
    .issue_last_i (issue_last),
    .all_retired_i(lane_idle),
    .opq_credit_i (opq_credit),
    .rd_issue_o   (rd_issue),
    .rd_addr_a_o  (rd_addr_a),
    .rd_addr_b_o  (rd_addr_b),
    .issue_idx_i  (issue_idx),
    .done_o       (done_o)
  );

  elem_counter i_counter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (cnt_start),
    .vl_i         (req.vl),
    .issue_i      (rd_issue),
    .retire_i     (retire),
    .issue_idx_o  (issue_idx),
    .issue_last_o (issue_last),
    .all_retired_o(all_retired)
  );

  //////////////////////////////
  // Datapath
  //////////////////////////////

  vector_regfile i_vrf (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_en_i    (rd_issue),
    .rd_addr_a_i(rd_addr_a),
    .rd_addr_b_i(rd_addr_b),
    .rd_data_a_o(rd_data_a),
    .rd_data_b_o(rd_data_b),
    .wr_en_i    (wr_en),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data)
  );

  operand_queue i_opq (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .alloc_i     (rd_issue),
    .alloc_idx_i (issue_idx),
    .rd_a_i      (rd_data_a),
    .rd_b_i      (rd_data_b),
    .credit_o    (opq_credit),
    .head_o      (opq_head),
    .head_valid_o(opq_head_valid),
    .head_ready_i(opq_head_ready)
  );

  vector_alu i_alu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .op_i        (cur_req.op),
    .vd_i        (cur_req.vd),
    .scalar_i    (cur_req.scalar),
    .opnd_i      (opq_head),
    .opnd_valid_i(opq_head_valid),
    .opnd_ready_o(opq_head_ready),
    .wr_en_o     (wr_en),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data),
    .rd_valid_o  (alu_rd_valid),
    .rd_data_o   (alu_rd_data),
    .rd_ready_i  (alu_rd_ready),
    .retire_o    (retire)
  );

  spill_register #(
    .T(elem_t)
  ) i_rd_spill (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(alu_rd_valid),
    .ready_o(alu_rd_ready),
    .data_i (alu_rd_data),
    .valid_o(rd_valid_o),
    .ready_i(rd_ready_i),
    .data_o (rd_data_o)
  );

endmodule

`default_nettype wire

//--- verilog/lane_pkg.sv
// Vector lane package with element sizes, opcodes and the request and queue payloads
`default_nettype none

package lane_pkg;

  //////////////////////////////
  // Lane geometry
  //////////////////////////////

  localparam int unsigned ElemWidth = 32;
  localparam int unsigned NrVRegs   = 8;
  localparam int unsigned VLenElems = 8;
  localparam int unsigned VrfDepth  = NrVRegs * VLenElems;

  // Operand queue sizing, counter needs one extra bit to reach QueueDepth
  localparam int unsigned QueueDepth    = 4;
  localparam int unsigned QueuePtrWidth = $clog2(QueueDepth);
  localparam int unsigned QueueCntWidth = QueuePtrWidth + 1;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [ElemWidth-1:0]         elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]   vreg_t;
  typedef logic [$clog2(VLenElems)-1:0] eidx_t;
  typedef logic [$clog2(VLenElems):0]   vl_t;
  typedef logic [$clog2(VrfDepth)-1:0]  vaddr_t;

  typedef enum logic [2:0] {
    VADD  = 3'd0,
    VSUB  = 3'd1,
    VAND  = 3'd2,
    VOR   = 3'd3,
    VXOR  = 3'd4,
    VMVI  = 3'd5,
    VREAD = 3'd6
  } lane_op_e;

  // One instruction as it enters the lane
  typedef struct packed {
    lane_op_e op;
    vreg_t    vd;
    vreg_t    vs1;
    vreg_t    vs2;
    elem_t    scalar;
    vl_t      vl;
  } lane_req_t;

  // Operand pair tagged with its element index
  typedef struct packed {
    elem_t a;
    elem_t b;
    eidx_t idx;
  } opq_entry_t;

endpackage

`default_nettype wire

//--- verilog/lane_sequencer.sv
// Lane sequencer FSM that takes one instruction, issues its element reads and reports completion
`timescale 1ns/1ps
`default_nettype none

module lane_sequencer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  lane_pkg::lane_req_t req_i,
  output lane_pkg::lane_req_t cur_req_o,
  output logic                cnt_start_o,
  input  logic                issue_last_i,
  input  logic                all_retired_i,
  input  logic                opq_credit_i,
  output logic                rd_issue_o,
  output lane_pkg::vaddr_t    rd_addr_a_o,
  output lane_pkg::vaddr_t    rd_addr_b_o,
  input  lane_pkg::eidx_t     issue_idx_i,
  output logic                done_o
);

  import lane_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN
  } seq_state_e;

  seq_state_e state_q, state_d;
  lane_req_t  cur_req_q;

  assign req_ready_o = (state_q == IDLE);
  assign cnt_start_o = req_valid_i && req_ready_o;

  // One read per cycle while the queue has credit
  assign rd_issue_o  = (state_q == ISSUE) && opq_credit_i;
  assign rd_addr_a_o = {cur_req_q.vs1, issue_idx_i};
  assign rd_addr_b_o = {cur_req_q.vs2, issue_idx_i};

  assign done_o    = (state_q == DRAIN) && all_retired_i;
  assign cur_req_o = cur_req_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (cnt_start_o) begin
          state_d = ISSUE;
        end
      end
      ISSUE: begin
        if (rd_issue_o && issue_last_i) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        if (all_retired_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload held for the whole instruction
  always_ff @(posedge clk_i) begin
    if (cnt_start_o) begin
      cur_req_q <= req_i;
    end
  end

  // Issue stops at the last element of the instruction
  a_issue_within_vl: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rd_issue_o |-> vl_t'(issue_idx_i) < cur_req_q.vl
  );

endmodule

`default_nettype wire

//--- verilog/operand_queue.sv
// Operand queue FIFO with a credit count that includes register file reads in flight
`timescale 1ns/1ps
`default_nettype none

module operand_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 alloc_i,
  input  lane_pkg::eidx_t      alloc_idx_i,
  input  lane_pkg::elem_t      rd_a_i,
  input  lane_pkg::elem_t      rd_b_i,
  output logic                 credit_o,
  output lane_pkg::opq_entry_t head_o,
  output logic                 head_valid_o,
  input  logic                 head_ready_i
);

  import lane_pkg::*;

  //////////////////////////////
  // Index pipe
  //////////////////////////////

  // Matches the one-cycle read latency of the register file
  logic  alloc_q;
  eidx_t idx_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alloc_q <= 1'b0;
    end else begin
      alloc_q <= alloc_i;
    end
  end

  always_ff @(posedge clk_i) begin
    idx_q <= alloc_idx_i;
  end

  //////////////////////////////
  // FIFO storage
  //////////////////////////////

  opq_entry_t               mem_q [QueueDepth];
  opq_entry_t               push_entry;
  logic [QueuePtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [QueueCntWidth-1:0] count_q;
  logic                     push, pop, full;

  assign push       = alloc_q;
  assign pop        = head_valid_o && head_ready_i;
  assign full       = (count_q == QueueCntWidth'(QueueDepth));
  assign push_entry = '{a: rd_a_i, b: rd_b_i, idx: idx_q};

  assign head_valid_o = (count_q != '0);
  assign head_o       = mem_q[rd_ptr_q];

  // Read issued last cycle already owns a slot
  assign credit_o = (count_q + QueueCntWidth'(alloc_q)) < QueueCntWidth'(QueueDepth);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + QueuePtrWidth'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + QueuePtrWidth'(1);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + QueueCntWidth'(1);
        2'b01:   count_q <= count_q - QueueCntWidth'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_entry;
    end
  end

  a_no_push_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    push |-> !full
  );

endmodule

`default_nettype wire

//--- verilog/spill_register.sv
// Spill register with a main and a spare slot, breaks the ready path between its two sides
`timescale 1ns/1ps
`default_nettype none

module spill_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Slot A takes new data, slot B keeps it when the sink stalls
  T     a_data_q, b_data_q;
  logic a_full_q, b_full_q;
  logic a_fill, a_drain, b_fill, b_drain;

  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // B is always older than A
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign ready_o = !a_full_q || !b_full_q;

  a_stable_while_stalled: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(data_o)
  );

endmodule

`default_nettype wire

//--- verilog/vector_alu.sv
// Integer ALU of the lane, consumes operand pairs and writes back or emits readback data
`timescale 1ns/1ps
`default_nettype none

module vector_alu (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lane_pkg::lane_op_e   op_i,
  input  lane_pkg::vreg_t      vd_i,
  input  lane_pkg::elem_t      scalar_i,
  input  lane_pkg::opq_entry_t opnd_i,
  input  logic                 opnd_valid_i,
  output logic                 opnd_ready_o,
  output logic                 wr_en_o,
  output lane_pkg::vaddr_t     wr_addr_o,
  output lane_pkg::elem_t      wr_data_o,
  output logic                 rd_valid_o,
  output lane_pkg::elem_t      rd_data_o,
  input  logic                 rd_ready_i,
  output logic                 retire_o
);

  import lane_pkg::*;

  logic is_read;
  logic pop;

  assign is_read = (op_i == VREAD);

  // Only readback can be stalled from downstream
  assign opnd_ready_o = is_read ? rd_ready_i : 1'b1;
  assign pop          = opnd_valid_i && opnd_ready_o;
  assign retire_o     = pop;

  assign rd_valid_o = opnd_valid_i && is_read;
  assign rd_data_o  = opnd_i.a;

  assign wr_en_o   = pop && !is_read;
  assign wr_addr_o = {vd_i, opnd_i.idx};

  always_comb begin
    case (op_i)
      VADD:    wr_data_o = opnd_i.a + opnd_i.b;
      VSUB:    wr_data_o = opnd_i.a - opnd_i.b;
      VAND:    wr_data_o = opnd_i.a & opnd_i.b;
      VOR:     wr_data_o = opnd_i.a | opnd_i.b;
      VXOR:    wr_data_o = opnd_i.a ^ opnd_i.b;
      // operands were read but are unused here
      VMVI:    wr_data_o = scalar_i + elem_t'(opnd_i.idx);
      default: wr_data_o = '0;
    endcase
  end

  // The queue head must hold while readback stalls
  a_readback_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rd_valid_o && !rd_ready_i |=> rd_valid_o && $stable(rd_data_o)
  );

endmodule

`default_nettype wire

//--- verilog/vector_regfile.sv
// Lane slice of the vector register file, two registered read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module vector_regfile (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             rd_en_i,
  input  lane_pkg::vaddr_t rd_addr_a_i,
  input  lane_pkg::vaddr_t rd_addr_b_i,
  output lane_pkg::elem_t  rd_data_a_o,
  output lane_pkg::elem_t  rd_data_b_o,
  input  logic             wr_en_i,
  input  lane_pkg::vaddr_t wr_addr_i,
  input  lane_pkg::elem_t  wr_data_i
);

  import lane_pkg::*;

  // Word address is {register, element}
  elem_t mem_q [VrfDepth];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '{default: '0};
    end else if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Reads see the array before this cycle's write
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_a_o <= mem_q[rd_addr_a_i];
      rd_data_b_o <= mem_q[rd_addr_b_i];
    end
  end

endmodule

`default_nettype wire
